// ==== sources.f ====
+incdir+include
hw/validator_pkg.sv
hw/pair_buffer.sv
hw/id_compare.sv
hw/result_stage.sv
hw/sha256_id_validator.sv
dv/tb_sha256_id_validator.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SHA-256 ID validator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f \
        --top-module tb_sha256_id_validator -Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation result: pass"
    exit 0
fi

echo "Simulation result: fail"
exit 1

// ==== include/validator_vectors.svh ====
//----------------------------------------
// Stimulus table for the validator testbench
// Hash-ID stream, expected-ID stream and output ready pattern
//----------------------------------------
`ifndef VALIDATOR_VECTORS_SVH
`define VALIDATOR_VECTORS_SVH

// Hash ID of each hash beat
// Entries from HASH_P1 on are sent after the status clear
localparam int HASH_P1 = 13;
localparam int HASH_N  = 16;
localparam pkt_id_t hash_id_tab [HASH_N] = '{
    6'd1, 6'd2, 6'd3,
    6'd3, 6'd5,
    6'd6,
    6'd2, 6'd62, 6'd2,
    6'd7, 6'd8, 6'd9, 6'd10,
    6'd11, 6'd12, 6'd13
};

// Expected IDs from the ID buffer, same phase split
localparam int ID_P1 = 13;
localparam int ID_N  = 15;
localparam pkt_id_t exp_id_tab [ID_N] = '{
    6'd1, 6'd2, 6'd3,
    6'd5,
    6'd4, 6'd6,
    6'd62, 6'd2, 6'd2,
    6'd7, 6'd8, 6'd9, 6'd10,
    6'd11, 6'd13
};

// hash_out_ready per cycle, repeated for the whole run
localparam int READY_N = 24;
localparam bit ready_tab [READY_N] = '{
    1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1,
    1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1
};

`endif

// ==== dv/tb_sha256_id_validator.sv ====
//----------------------------------------
// Testbench for the SHA-256 ID validator
// Streams hashes and expected IDs from a table and checks every beat
//----------------------------------------
module tb_sha256_id_validator;
    timeunit 1ns;
    timeprecision 1ps;
    import validator_pkg::*;

    `include "validator_vectors.svh"

    localparam int WAIT_MAX = 500;

    logic        clk;
    logic        nrst;
    hash_t       hash_in;
    pkt_id_t     hash_in_id;
    logic        hash_in_valid;
    logic        hash_in_ready;
    pkt_id_t     id_in_buf;
    logic        id_in_buf_valid;
    logic        id_in_buf_ready;
    hash_t       hash_out;
    logic        hash_out_err;
    logic        hash_out_valid;
    logic        hash_out_ready;
    logic        status_clear;
    status_err_t status_err;
    pkt_count_t  status_packet_count;

    hash_t       hash_data [HASH_N];
    hash_t       exp_hash_q [$];
    logic        exp_err_q [$];
    status_err_t exp_status_q [$];
    pkt_count_t  exp_count_q [$];
    status_err_t model_status;
    pkt_count_t  model_count;
    int          beats_predicted;
    int          beats_seen;
    logic        was_stalled;
    hash_t       stalled_hash;
    logic        stalled_err;

    sha256_id_validator sha256_id_validator_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Low IDs facing an ID with the top bit set are lifted by one full ID range
    function automatic bit is_newer(input pkt_id_t a, input pkt_id_t b);
        int ua;
        int ub;
        ua = int'(a);
        ub = int'(b);
        if (ua < WRAP_WIN_DEF && b[ID_W_DEF-1]) begin
            ua += 1 << ID_W_DEF;
        end
        if (ub < WRAP_WIN_DEF && a[ID_W_DEF-1]) begin
            ub += 1 << ID_W_DEF;
        end
        return ua > ub;
    endfunction

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", WAIT_MAX, what);
        stop_run();
    endtask

    task automatic check_hash(input hash_t got, input hash_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_status(input status_err_t got_err, input pkt_count_t got_cnt,
                                input status_err_t exp_err, input pkt_count_t exp_cnt);
        if (got_err !== exp_err || got_cnt !== exp_cnt) begin
            $display("** Error at %0t ns: status is %b count %0d, expected %b count %0d",
                     $time, got_err, got_cnt, exp_err, exp_cnt);
            stop_run();
        end
    endtask

    // Reference model of one phase, queues each beat with the status after it
    task automatic predict_phase(input int h_lo, input int h_hi, input int i_lo, input int i_hi);
        int   h;
        int   i;
        logic err;
        h = h_lo;
        i = i_lo;
        while (h < h_hi && i < i_hi) begin
            exp_hash_q.push_back(hash_data[h]);
            if (hash_id_tab[h] == exp_id_tab[i]) begin
                err = 1'b0;
                h++;
                i++;
            end else if (is_newer(exp_id_tab[i], hash_id_tab[h])) begin
                // ID buffer skipped ahead of this hash
                err = 1'b1;
                model_status[1] = 1'b1;
                h++;
            end else begin
                err = 1'b1;
                model_status[0] = 1'b1;
                i++;
            end
            model_count = model_count + pkt_count_t'(1);
            beats_predicted++;
            exp_err_q.push_back(err);
            exp_status_q.push_back(model_status);
            exp_count_q.push_back(model_count);
        end
        if (h != h_hi || i != i_hi) begin
            $display("Stimulus table leaves entries that never pair up");
            stop_run();
        end
    endtask

    task automatic drive_hashes(input int lo, input int hi);
        int cycles;
        @(posedge clk);
        for (int k = lo; k < hi; k++) begin
            hash_in       <= hash_data[k];
            hash_in_id    <= hash_id_tab[k];
            hash_in_valid <= 1'b1;
            cycles = 0;
            @(negedge clk);
            while (!hash_in_ready) begin
                cycles++;
                if (cycles > WAIT_MAX) begin
                    report_timeout("hash_in_ready");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        hash_in_valid <= 1'b0;
    endtask

    task automatic drive_ids(input int lo, input int hi);
        int cycles;
        @(posedge clk);
        for (int k = lo; k < hi; k++) begin
            id_in_buf       <= exp_id_tab[k];
            id_in_buf_valid <= 1'b1;
            cycles = 0;
            @(negedge clk);
            while (!id_in_buf_ready) begin
                cycles++;
                if (cycles > WAIT_MAX) begin
                    report_timeout("id_in_buf_ready");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        id_in_buf_valid <= 1'b0;
    endtask

    task automatic wait_beats(input int total);
        int cycles;
        cycles = 0;
        while (beats_seen < total) begin
            cycles++;
            if (cycles > WAIT_MAX) begin
                report_timeout("output beats");
            end
            @(negedge clk);
        end
    endtask

    // Output ready follows the stall table
    initial begin
        int cyc;
        cyc = 0;
        hash_out_ready = 1'b0;
        forever begin
            @(posedge clk);
            hash_out_ready <= ready_tab[cyc % READY_N];
            cyc++;
        end
    end

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (nrst && was_stalled) begin
            check_err(hash_out_valid, 1'b1, "hash_out_valid under stall");
            check_hash(hash_out, stalled_hash, "stalled hash_out");
            check_err(hash_out_err, stalled_err, "stalled hash_out_err");
        end
        was_stalled  = nrst && hash_out_valid && !hash_out_ready;
        stalled_hash = hash_out;
        stalled_err  = hash_out_err;
        if (nrst && hash_out_valid && hash_out_ready) begin
            if (exp_hash_q.size() == 0) begin
                $display("DUT sent an output beat that the model does not predict");
                stop_run();
            end
            check_hash(hash_out, exp_hash_q[0], "hash_out");
            check_err(hash_out_err, exp_err_q[0], "hash_out_err");
            check_status(status_err, status_packet_count, exp_status_q[0], exp_count_q[0]);
            void'(exp_hash_q.pop_front());
            void'(exp_err_q.pop_front());
            void'(exp_status_q.pop_front());
            void'(exp_count_q.pop_front());
            beats_seen++;
        end
    end

    initial begin
        logic [31:0] rng;
        nrst            = 1'b0;
        hash_in         = '0;
        hash_in_id      = '0;
        hash_in_valid   = 1'b0;
        id_in_buf       = '0;
        id_in_buf_valid = 1'b0;
        status_clear    = 1'b0;
        was_stalled     = 1'b0;
        beats_seen      = 0;
        beats_predicted = 0;
        model_status    = '0;
        model_count     = '0;
        rng             = 32'd7;
        for (int k = 0; k < HASH_N; k++) begin
            for (int w = 0; w < HASH_W_DEF / 32; w++) begin
                rng = xorshift32(rng);
                hash_data[k][w*32 +: 32] = rng;
            end
        end
        predict_phase(0, HASH_P1, 0, ID_P1);

        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_err(hash_out_valid, 1'b0, "hash_out_valid after reset");
        check_err(hash_in_ready, 1'b1, "hash_in_ready after reset");
        check_err(id_in_buf_ready, 1'b1, "id_in_buf_ready after reset");
        check_status(status_err, status_packet_count, '0, '0);

        // Matches, stale hash, stale ID and wrap cases under output stalls
        fork
            drive_hashes(0, HASH_P1);
            drive_ids(0, ID_P1);
        join
        wait_beats(beats_predicted);
        @(posedge clk);
        @(negedge clk);
        check_status(status_err, status_packet_count, model_status, model_count);

        // Clear zeroes the sticky bits and keeps the count
        @(posedge clk);
        status_clear <= 1'b1;
        @(posedge clk);
        status_clear <= 1'b0;
        @(negedge clk);
        model_status = '0;
        check_status(status_err, status_packet_count, model_status, model_count);

        predict_phase(HASH_P1, HASH_N, ID_P1, ID_N);
        fork
            drive_hashes(HASH_P1, HASH_N);
            drive_ids(ID_P1, ID_N);
        join
        wait_beats(beats_predicted);
        repeat (10) @(negedge clk);
        check_status(status_err, status_packet_count, model_status, model_count);

        if (exp_hash_q.size() == 0 && beats_seen == beats_predicted) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Output beats are missing at the end of the run");
            stop_run();
        end
    end

endmodule

// ==== hw/sha256_id_validator.sv ====
//----------------------------------------
// SHA-256 ID validator top level
// Pairs hashes with expected IDs and reports each comparison
//----------------------------------------
module sha256_id_validator #(
    parameter int HASH_W   = validator_pkg::HASH_W_DEF,
    parameter int ID_W     = validator_pkg::ID_W_DEF,
    parameter int WRAP_WIN = validator_pkg::WRAP_WIN_DEF,
    parameter int COUNT_W  = validator_pkg::COUNT_W_DEF
) (
    input  logic                       clk,
    input  logic                       nrst,

    // Hash stream
    input  logic [HASH_W-1:0]          hash_in,
    input  logic [ID_W-1:0]            hash_in_id,
    input  logic                       hash_in_valid,
    output logic                       hash_in_ready,

    // Expected ID stream
    input  logic [ID_W-1:0]            id_in_buf,
    input  logic                       id_in_buf_valid,
    output logic                       id_in_buf_ready,

    // Result stream
    output logic [HASH_W-1:0]          hash_out,
    output logic                       hash_out_err,
    output logic                       hash_out_valid,
    input  logic                       hash_out_ready,

    // Status, updated with each beat
    input  logic                       status_clear,
    output validator_pkg::status_err_t status_err,
    output logic [COUNT_W-1:0]         status_packet_count
);
    import validator_pkg::*;

    logic [HASH_W-1:0] held_hash;
    logic [ID_W-1:0]   held_hash_id;
    logic [ID_W-1:0]   held_id;
    cmp_result_t       cmp_result;
    logic              accept;
    logic              pair_fire;

    pair_buffer #(
        .HASH_W (HASH_W),
        .ID_W   (ID_W)
    ) pair_buffer_i (
        .clk             (clk),
        .nrst            (nrst),
        .hash_in         (hash_in),
        .hash_in_id      (hash_in_id),
        .hash_in_valid   (hash_in_valid),
        .hash_in_ready   (hash_in_ready),
        .id_in_buf       (id_in_buf),
        .id_in_buf_valid (id_in_buf_valid),
        .id_in_buf_ready (id_in_buf_ready),
        .accept          (accept),
        .cmp_result      (cmp_result),
        .held_hash       (held_hash),
        .held_hash_id    (held_hash_id),
        .held_id         (held_id),
        .pair_fire       (pair_fire)
    );

    id_compare #(
        .ID_W     (ID_W),
        .WRAP_WIN (WRAP_WIN)
    ) id_compare_i (
        .held_id      (held_id),
        .held_hash_id (held_hash_id),
        .cmp_result   (cmp_result)
    );

    result_stage #(
        .HASH_W  (HASH_W),
        .COUNT_W (COUNT_W)
    ) result_stage_i (
        .clk                 (clk),
        .nrst                (nrst),
        .pair_fire           (pair_fire),
        .held_hash           (held_hash),
        .cmp_result          (cmp_result),
        .accept              (accept),
        .hash_out            (hash_out),
        .hash_out_err        (hash_out_err),
        .hash_out_valid      (hash_out_valid),
        .hash_out_ready      (hash_out_ready),
        .status_clear        (status_clear),
        .status_err          (status_err),
        .status_packet_count (status_packet_count)
    );

endmodule

// ==== hw/result_stage.sv ====
//----------------------------------------
// Output register with valid/ready, error flag, sticky status
// bits and a wrapping packet counter
//----------------------------------------
module result_stage #(
    parameter int HASH_W  = validator_pkg::HASH_W_DEF,
    parameter int COUNT_W = validator_pkg::COUNT_W_DEF
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       pair_fire,
    input  logic [HASH_W-1:0]          held_hash,
    input  validator_pkg::cmp_result_t cmp_result,
    output logic                       accept,
    output logic [HASH_W-1:0]          hash_out,
    output logic                       hash_out_err,
    output logic                       hash_out_valid,
    input  logic                       hash_out_ready,
    input  logic                       status_clear,
    output validator_pkg::status_err_t status_err,
    output logic [COUNT_W-1:0]         status_packet_count
);
    import validator_pkg::*;

    status_err_t beat_err;
    status_err_t status_err_next;

    // Room for a beat when empty or draining this cycle
    assign accept = !hash_out_valid || hash_out_ready;

    always_comb begin
        beat_err               = '0;
        beat_err[ERR_ID_SKIP]  = pair_fire && (cmp_result == CMP_HASH_STALE);
        beat_err[ERR_PKT_LOST] = pair_fire && (cmp_result == CMP_ID_STALE);
    end

    // Clear applies first so a set on the same edge still lands
    assign status_err_next = (status_clear ? '0 : status_err) | beat_err;

    // ----------------------------------------
    // Output beat
    // ----------------------------------------
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hash_out_valid <= 1'b0;
        end else if (pair_fire) begin
            hash_out_valid <= 1'b1;
        end else if (hash_out_ready) begin
            hash_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pair_fire) begin
            hash_out     <= held_hash;
            hash_out_err <= (cmp_result != CMP_MATCH);
        end
    end

    // ----------------------------------------
    // Status
    // ----------------------------------------
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            status_err          <= '0;
            status_packet_count <= '0;
        end else begin
            status_err <= status_err_next;
            if (pair_fire) begin
                status_packet_count <= status_packet_count + COUNT_W'(1);
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_hold_stall: assert property (@(posedge clk) disable iff (!nrst)
        (hash_out_valid && !hash_out_ready) |=>
            hash_out_valid && $stable(hash_out) && $stable(hash_out_err));

    // A fire from the pair buffer never lands on an undrained beat
    a_fire_room: assert property (@(posedge clk) disable iff (!nrst)
        pair_fire |-> accept);

endmodule

// ==== hw/id_compare.sv ====
//----------------------------------------
// Wrap-aware ordering of the expected ID against the hash ID
//----------------------------------------
module id_compare #(
    parameter int ID_W     = validator_pkg::ID_W_DEF,
    parameter int WRAP_WIN = validator_pkg::WRAP_WIN_DEF
) (
    input  logic [ID_W-1:0]             held_id,
    input  logic [ID_W-1:0]             held_hash_id,
    output validator_pkg::cmp_result_t  cmp_result
);
    import validator_pkg::*;

    localparam logic [ID_W-1:0] WIN = ID_W'(WRAP_WIN);

    // True when a is newer than b, counting low IDs just past the wrap as newer
    function automatic logic ahead(input logic [ID_W-1:0] a, input logic [ID_W-1:0] b);
        logic a_top;
        logic b_top;
        a_top = a[ID_W-1];
        b_top = b[ID_W-1];
        if (!a_top && b_top && (a < WIN)) begin
            return 1'b1;
        end
        if (a_top && !b_top && (b < WIN)) begin
            return 1'b0;
        end
        return a > b;
    endfunction

    always_comb begin
        if (held_id == held_hash_id) begin
            cmp_result = CMP_MATCH;
        end else if (ahead(held_id, held_hash_id)) begin
            // Expected ID moved on, the hash is old
            cmp_result = CMP_HASH_STALE;
        end else begin
            cmp_result = CMP_ID_STALE;
        end
    end

    // Held IDs are unset until first loaded
    always_comb begin
        if (!$isunknown({held_id, held_hash_id})) begin
            a_known: assert (!$isunknown(cmp_result));
        end
    end

endmodule

// ==== hw/pair_buffer.sv ====
//----------------------------------------
// Holds one hash and one expected ID until both are present,
// then fires the pair and frees slots by comparison result
//----------------------------------------
module pair_buffer #(
    parameter int HASH_W = validator_pkg::HASH_W_DEF,
    parameter int ID_W   = validator_pkg::ID_W_DEF
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [HASH_W-1:0]          hash_in,
    input  logic [ID_W-1:0]            hash_in_id,
    input  logic                       hash_in_valid,
    output logic                       hash_in_ready,
    input  logic [ID_W-1:0]            id_in_buf,
    input  logic                       id_in_buf_valid,
    output logic                       id_in_buf_ready,
    input  logic                       accept,
    input  validator_pkg::cmp_result_t cmp_result,
    output logic [HASH_W-1:0]          held_hash,
    output logic [ID_W-1:0]            held_hash_id,
    output logic [ID_W-1:0]            held_id,
    output logic                       pair_fire
);
    import validator_pkg::*;

    pair_state_t state;
    pair_state_t state_next;
    logic        hash_full;
    logic        id_full;
    logic        hash_hs;
    logic        id_hs;
    logic        free_hash;
    logic        free_id;
    logic        hash_full_next;
    logic        id_full_next;

    assign hash_full = (state == PAIR_HASH) || (state == PAIR_BOTH);
    assign id_full   = (state == PAIR_ID) || (state == PAIR_BOTH);

    // A slot takes new data whenever it is empty
    assign hash_in_ready   = !hash_full;
    assign id_in_buf_ready = !id_full;
    assign hash_hs         = hash_in_valid && hash_in_ready;
    assign id_hs           = id_in_buf_valid && id_in_buf_ready;

    // Stale hash keeps the ID, stale ID keeps the hash
    assign free_hash = pair_fire && (cmp_result != CMP_ID_STALE);
    assign free_id   = pair_fire && (cmp_result != CMP_HASH_STALE);

    assign hash_full_next = (hash_full && !free_hash) || hash_hs;
    assign id_full_next   = (id_full && !free_id) || id_hs;

    always_comb begin
        case ({id_full_next, hash_full_next})
            2'b00:   state_next = PAIR_EMPTY;
            2'b01:   state_next = PAIR_HASH;
            2'b10:   state_next = PAIR_ID;
            default: state_next = PAIR_BOTH;
        endcase
    end

    // Fire is registered, and blocked while a fire is already in flight
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= PAIR_EMPTY;
            pair_fire <= 1'b0;
        end else begin
            state     <= state_next;
            pair_fire <= (state == PAIR_BOTH) && accept && !pair_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (hash_hs) begin
            held_hash    <= hash_in;
            held_hash_id <= hash_in_id;
        end
        if (id_hs) begin
            held_id <= id_in_buf;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // A held slot is neither overwritten nor dropped until it is freed
    a_no_fill_full: assert property (@(posedge clk) disable iff (!nrst)
        (hash_full && !free_hash) |=>
            hash_full && $stable(held_hash) && $stable(held_hash_id));

    a_no_fill_full_id: assert property (@(posedge clk) disable iff (!nrst)
        (id_full && !free_id) |=> id_full && $stable(held_id));

    a_fire_both: assert property (@(posedge clk) disable iff (!nrst)
        pair_fire |-> (state == PAIR_BOTH));

endmodule

// ==== hw/validator_pkg.sv ====
//----------------------------------------
// Widths, types and enums shared by the SHA-256 ID validator
// Imported by each RTL block and by the testbench
//----------------------------------------
package validator_pkg;

    // Default widths, overridden from the top level
    localparam int HASH_W_DEF   = 256;
    localparam int ID_W_DEF     = 6;
    localparam int COUNT_W_DEF  = 10;

    // Number of low IDs treated as newer than IDs with the top bit set
    localparam int WRAP_WIN_DEF = 10;

    // Bit positions in the status error field
    localparam int ERR_ID_SKIP  = 1;
    localparam int ERR_PKT_LOST = 0;

    typedef logic [HASH_W_DEF-1:0]  hash_t;
    typedef logic [ID_W_DEF-1:0]    pkt_id_t;
    typedef logic [COUNT_W_DEF-1:0] pkt_count_t;

    // Bit 1 set by a stale hash, bit 0 set by a stale ID
    typedef logic [1:0] status_err_t;

    // Outcome of comparing the expected ID with the hash ID
    typedef enum logic [1:0] {
        CMP_MATCH,
        CMP_HASH_STALE,
        CMP_ID_STALE
    } cmp_result_t;

    // Which slots of the pair buffer hold data
    typedef enum logic [1:0] {
        PAIR_EMPTY,
        PAIR_HASH,
        PAIR_ID,
        PAIR_BOTH
    } pair_state_t;

endpackage
